/* hdl/alu_pkg.sv */
package alu_pkg;

  // Data path and register file
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  // APB address map
  localparam int                    APB_ADDR_W    = 12;
  localparam logic [APB_ADDR_W-1:0] ADDR_INSTR    = 12'h000;
  localparam logic [APB_ADDR_W-1:0] ADDR_REG_BASE = 12'h080;

  // Major opcodes
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SR      = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // ALU operation codes
  localparam int                  ALU_OP_W   = 4;
  localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'd1;
  localparam logic [ALU_OP_W-1:0] ALU_SLL    = 4'd2;
  localparam logic [ALU_OP_W-1:0] ALU_SLT    = 4'd3;
  localparam logic [ALU_OP_W-1:0] ALU_SLTU   = 4'd4;
  localparam logic [ALU_OP_W-1:0] ALU_XOR    = 4'd5;
  localparam logic [ALU_OP_W-1:0] ALU_OR     = 4'd6;
  localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'd7;
  localparam logic [ALU_OP_W-1:0] ALU_SRL    = 4'd8;
  localparam logic [ALU_OP_W-1:0] ALU_SRA    = 4'd9;
  localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'd10;

  // One instruction word, three field layouts
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [19:0] imm20;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
  } instr_u;

endpackage

/* hdl/alu_regfile.sv */
`timescale 1ns/10ps

module alu_regfile (
  input  logic                           in_clk,
  input  logic                           in_rst,
  input  logic [alu_pkg::REG_ADDR_W-1:0] raddr_1_i,
  input  logic [alu_pkg::REG_ADDR_W-1:0] raddr_2_i,
  input  logic [alu_pkg::REG_ADDR_W-1:0] raddr_3_i,
  input  logic                           wb_en_i,
  input  logic [alu_pkg::REG_ADDR_W-1:0] wb_addr_i,
  input  logic [alu_pkg::XLEN-1:0]       wb_data_i,
  input  logic                           bus_en_i,
  input  logic [alu_pkg::REG_ADDR_W-1:0] bus_addr_i,
  input  logic [alu_pkg::XLEN-1:0]       bus_data_i,
  output logic [alu_pkg::XLEN-1:0]       rdata_1_o,
  output logic [alu_pkg::XLEN-1:0]       rdata_2_o,
  output logic [alu_pkg::XLEN-1:0]       rdata_3_o
);

  // No storage behind x0
  logic [alu_pkg::XLEN-1:0] regs [1:alu_pkg::NUM_REGS-1];

  always_ff @(posedge in_clk or negedge in_rst) begin
    if (!in_rst) begin
      for (int i = 1; i < alu_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en_i) begin
      if (wb_addr_i != '0) begin
        regs[wb_addr_i] <= wb_data_i;
      end
    end else if (bus_en_i && bus_addr_i != '0) begin
      regs[bus_addr_i] <= bus_data_i;
    end
  end

  assign rdata_1_o = (raddr_1_i == '0) ? '0 : regs[raddr_1_i];
  assign rdata_2_o = (raddr_2_i == '0) ? '0 : regs[raddr_2_i];
  assign rdata_3_o = (raddr_3_i == '0) ? '0 : regs[raddr_3_i];

endmodule

/* hdl/alu_decoder.sv */
`timescale 1ns/10ps

module alu_decoder (
  input  alu_pkg::instr_u                instr_i,
  output logic [alu_pkg::ALU_OP_W-1:0]   alu_op_o,
  output logic [alu_pkg::REG_ADDR_W-1:0] rs1_o,
  output logic [alu_pkg::REG_ADDR_W-1:0] rs2_o,
  output logic [alu_pkg::REG_ADDR_W-1:0] rd_o,
  output logic [alu_pkg::XLEN-1:0]       imm_o,
  output logic                           use_imm_o,
  output logic                           illegal_o
);

  // Register fields share positions in every layout
  assign rs1_o = instr_i.r.rs1;
  assign rs2_o = instr_i.r.rs2;
  assign rd_o  = instr_i.r.rd;

  always_comb begin
    alu_op_o  = alu_pkg::ALU_ADD;
    imm_o     = '0;
    use_imm_o = 1'b0;
    illegal_o = 1'b1;
    case (instr_i.r.opcode)
      alu_pkg::OPC_LUI: begin
        alu_op_o  = alu_pkg::ALU_PASS_B;
        imm_o     = {instr_i.u.imm20, 12'b0};
        use_imm_o = 1'b1;
        illegal_o = 1'b0;
      end
      alu_pkg::OPC_OP_IMM: begin
        imm_o     = {{(alu_pkg::XLEN-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};
        use_imm_o = 1'b1;
        illegal_o = 1'b0;
        case (instr_i.i.funct3)
          alu_pkg::F3_ADD_SUB: alu_op_o = alu_pkg::ALU_ADD;
          alu_pkg::F3_SLT:     alu_op_o = alu_pkg::ALU_SLT;
          alu_pkg::F3_SLTU:    alu_op_o = alu_pkg::ALU_SLTU;
          alu_pkg::F3_XOR:     alu_op_o = alu_pkg::ALU_XOR;
          alu_pkg::F3_OR:      alu_op_o = alu_pkg::ALU_OR;
          alu_pkg::F3_AND:     alu_op_o = alu_pkg::ALU_AND;
          alu_pkg::F3_SLL: begin
            alu_op_o  = alu_pkg::ALU_SLL;
            illegal_o = (instr_i.i.imm12[11:5] != alu_pkg::F7_BASE);
          end
          default: begin
            // Shift right, upper immediate bits pick the form
            if (instr_i.i.imm12[11:5] == alu_pkg::F7_BASE) begin
              alu_op_o = alu_pkg::ALU_SRL;
            end else if (instr_i.i.imm12[11:5] == alu_pkg::F7_ALT) begin
              alu_op_o = alu_pkg::ALU_SRA;
            end else begin
              illegal_o = 1'b1;
            end
          end
        endcase
      end
      alu_pkg::OPC_OP: begin
        illegal_o = 1'b0;
        case ({instr_i.r.funct7, instr_i.r.funct3})
          {alu_pkg::F7_BASE, alu_pkg::F3_ADD_SUB}: alu_op_o = alu_pkg::ALU_ADD;
          {alu_pkg::F7_ALT, alu_pkg::F3_ADD_SUB}:  alu_op_o = alu_pkg::ALU_SUB;
          {alu_pkg::F7_BASE, alu_pkg::F3_SLL}:     alu_op_o = alu_pkg::ALU_SLL;
          {alu_pkg::F7_BASE, alu_pkg::F3_SLT}:     alu_op_o = alu_pkg::ALU_SLT;
          {alu_pkg::F7_BASE, alu_pkg::F3_SLTU}:    alu_op_o = alu_pkg::ALU_SLTU;
          default:                                 illegal_o = 1'b1;
        endcase
      end
      default: begin
        illegal_o = 1'b1;
      end
    endcase
  end

endmodule

/* hdl/alu_execute.sv */
`timescale 1ns/10ps

module alu_execute (
  input  logic                           in_clk,
  input  logic                           in_rst,
  input  logic                           issue_i,
  input  logic [alu_pkg::ALU_OP_W-1:0]   alu_op_i,
  input  logic [alu_pkg::REG_ADDR_W-1:0] rs1_i,
  input  logic [alu_pkg::REG_ADDR_W-1:0] rs2_i,
  input  logic [alu_pkg::REG_ADDR_W-1:0] rd_i,
  input  logic [alu_pkg::XLEN-1:0]       imm_i,
  input  logic                           use_imm_i,
  input  logic [alu_pkg::XLEN-1:0]       rdata_1_i,
  input  logic [alu_pkg::XLEN-1:0]       rdata_2_i,
  output logic [alu_pkg::REG_ADDR_W-1:0] raddr_1_o,
  output logic [alu_pkg::REG_ADDR_W-1:0] raddr_2_o,
  output logic                           wb_valid_o,
  output logic [alu_pkg::REG_ADDR_W-1:0] wb_addr_o,
  output logic [alu_pkg::XLEN-1:0]       wb_data_o
);

  logic                           op_valid;
  logic [alu_pkg::ALU_OP_W-1:0]   op_q;
  logic [alu_pkg::REG_ADDR_W-1:0] rd_q;
  logic [alu_pkg::XLEN-1:0]       opa_q;
  logic [alu_pkg::XLEN-1:0]       opb_q;
  logic [4:0]                     shamt;
  logic [alu_pkg::XLEN-1:0]       result;

  // Source registers read in the issue cycle
  assign raddr_1_o = rs1_i;
  assign raddr_2_o = rs2_i;

  always_ff @(posedge in_clk or negedge in_rst) begin
    if (!in_rst) begin
      op_valid   <= 1'b0;
      wb_valid_o <= 1'b0;
    end else begin
      op_valid   <= issue_i;
      wb_valid_o <= op_valid;
    end
  end

  // Stage one operand capture
  always_ff @(posedge in_clk) begin
    if (issue_i) begin
      op_q  <= alu_op_i;
      rd_q  <= rd_i;
      opa_q <= rdata_1_i;
      opb_q <= use_imm_i ? imm_i : rdata_2_i;
    end
  end

  assign shamt = opb_q[4:0];

  always_comb begin
    case (op_q)
      alu_pkg::ALU_ADD:    result = opa_q + opb_q;
      alu_pkg::ALU_SUB:    result = opa_q - opb_q;
      alu_pkg::ALU_SLL:    result = opa_q << shamt;
      alu_pkg::ALU_SLT:    result = {{(alu_pkg::XLEN-1){1'b0}}, $signed(opa_q) < $signed(opb_q)};
      alu_pkg::ALU_SLTU:   result = {{(alu_pkg::XLEN-1){1'b0}}, opa_q < opb_q};
      alu_pkg::ALU_XOR:    result = opa_q ^ opb_q;
      alu_pkg::ALU_OR:     result = opa_q | opb_q;
      alu_pkg::ALU_AND:    result = opa_q & opb_q;
      alu_pkg::ALU_SRL:    result = opa_q >> shamt;
      alu_pkg::ALU_SRA:    result = $unsigned($signed(opa_q) >>> shamt);
      alu_pkg::ALU_PASS_B: result = opb_q;
      default:             result = '0;
    endcase
  end

  // Stage two result register
  always_ff @(posedge in_clk) begin
    if (op_valid) begin
      wb_addr_o <= rd_q;
      wb_data_o <= result;
    end
  end

endmodule

/* hdl/alu_apb_slave.sv */
`timescale 1ns/10ps

module alu_apb_slave (
  input  logic                            in_clk,
  input  logic                            in_rst,
  input  logic [alu_pkg::APB_ADDR_W-1:0]  paddr_i,
  input  logic                            psel_i,
  input  logic                            penable_i,
  input  logic                            pwrite_i,
  input  logic [alu_pkg::XLEN-1:0]        pwdata_i,
  input  logic                            illegal_i,
  input  logic                            wb_valid_i,
  input  logic [alu_pkg::XLEN-1:0]        reg_rdata_i,
  output logic [alu_pkg::XLEN-1:0]        prdata_o,
  output logic                            pready_o,
  output logic                            pslverr_o,
  output logic                            issue_o,
  output logic                            reg_we_o,
  output logic [alu_pkg::REG_ADDR_W-1:0]  reg_addr_o,
  output logic [alu_pkg::XLEN-1:0]        reg_wdata_o
);

  logic                           access;
  logic                           instr_hit;
  logic                           reg_hit;
  logic                           instr_wr;
  logic                           reg_acc;
  logic                           bad_acc;
  logic                           busy;
  logic [alu_pkg::APB_ADDR_W-1:0] reg_offset;

  assign access = psel_i & penable_i;

  // Address decode
  assign instr_hit  = (paddr_i == alu_pkg::ADDR_INSTR);
  assign reg_offset = paddr_i - alu_pkg::ADDR_REG_BASE;
  assign reg_hit    = (paddr_i >= alu_pkg::ADDR_REG_BASE) &&
                      (paddr_i <= alu_pkg::ADDR_REG_BASE + 4 * (alu_pkg::NUM_REGS - 1)) &&
                      (paddr_i[1:0] == 2'b00);

  assign instr_wr = access & instr_hit & pwrite_i;
  assign reg_acc  = access & reg_hit;
  // Instruction register is write only
  assign bad_acc  = access & ~instr_wr & ~reg_acc;

  // Only the first access cycle of a legal instruction issues
  assign issue_o = instr_wr & ~illegal_i & ~busy;

  always_ff @(posedge in_clk or negedge in_rst) begin
    if (!in_rst) begin
      busy <= 1'b0;
    end else if (issue_o) begin
      busy <= 1'b1;
    end else if (wb_valid_i) begin
      busy <= 1'b0;
    end
  end

  // Legal instructions complete with the writeback cycle
  assign pready_o  = reg_acc | bad_acc | (instr_wr & (illegal_i | wb_valid_i));
  assign pslverr_o = bad_acc | (instr_wr & illegal_i);

  // Register window
  assign reg_we_o    = reg_acc & pwrite_i;
  assign reg_addr_o  = reg_offset[alu_pkg::REG_ADDR_W+1:2];
  assign reg_wdata_o = pwdata_i;
  assign prdata_o    = (reg_acc & ~pwrite_i) ? reg_rdata_i : '0;

endmodule

/* hdl/alu_exec_top.sv */
`timescale 1ns/10ps

module alu_exec_top (
  input  logic                           in_clk,
  input  logic                           in_rst,
  input  logic [alu_pkg::APB_ADDR_W-1:0] paddr_i,
  input  logic                           psel_i,
  input  logic                           penable_i,
  input  logic                           pwrite_i,
  input  logic [alu_pkg::XLEN-1:0]       pwdata_i,
  output logic [alu_pkg::XLEN-1:0]       prdata_o,
  output logic                           pready_o,
  output logic                           pslverr_o
);

  logic                           illegal;
  logic                           issue;
  logic [alu_pkg::ALU_OP_W-1:0]   alu_op;
  logic [alu_pkg::REG_ADDR_W-1:0] rs1;
  logic [alu_pkg::REG_ADDR_W-1:0] rs2;
  logic [alu_pkg::REG_ADDR_W-1:0] rd;
  logic [alu_pkg::XLEN-1:0]       imm;
  logic                           use_imm;
  // Execute side of the register file
  logic [alu_pkg::REG_ADDR_W-1:0] raddr_1;
  logic [alu_pkg::REG_ADDR_W-1:0] raddr_2;
  logic [alu_pkg::XLEN-1:0]       rdata_1;
  logic [alu_pkg::XLEN-1:0]       rdata_2;
  logic                           wb_valid;
  logic [alu_pkg::REG_ADDR_W-1:0] wb_addr;
  logic [alu_pkg::XLEN-1:0]       wb_data;
  // Bus side of the register file
  logic                           reg_we;
  logic [alu_pkg::REG_ADDR_W-1:0] reg_addr;
  logic [alu_pkg::XLEN-1:0]       reg_wdata;
  logic [alu_pkg::XLEN-1:0]       reg_rdata;

  alu_apb_slave u_apb_slave (
    .in_clk      (in_clk),
    .in_rst      (in_rst),
    .paddr_i     (paddr_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .pwdata_i    (pwdata_i),
    .illegal_i   (illegal),
    .wb_valid_i  (wb_valid),
    .reg_rdata_i (reg_rdata),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .issue_o     (issue),
    .reg_we_o    (reg_we),
    .reg_addr_o  (reg_addr),
    .reg_wdata_o (reg_wdata)
  );

  alu_decoder u_decoder (
    .instr_i   (alu_pkg::instr_u'(pwdata_i)),
    .alu_op_o  (alu_op),
    .rs1_o     (rs1),
    .rs2_o     (rs2),
    .rd_o      (rd),
    .imm_o     (imm),
    .use_imm_o (use_imm),
    .illegal_o (illegal)
  );

  alu_execute u_execute (
    .in_clk     (in_clk),
    .in_rst     (in_rst),
    .issue_i    (issue),
    .alu_op_i   (alu_op),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rd_i       (rd),
    .imm_i      (imm),
    .use_imm_i  (use_imm),
    .rdata_1_i  (rdata_1),
    .rdata_2_i  (rdata_2),
    .raddr_1_o  (raddr_1),
    .raddr_2_o  (raddr_2),
    .wb_valid_o (wb_valid),
    .wb_addr_o  (wb_addr),
    .wb_data_o  (wb_data)
  );

  alu_regfile u_regfile (
    .in_clk     (in_clk),
    .in_rst     (in_rst),
    .raddr_1_i  (raddr_1),
    .raddr_2_i  (raddr_2),
    .raddr_3_i  (reg_addr),
    .wb_en_i    (wb_valid),
    .wb_addr_i  (wb_addr),
    .wb_data_i  (wb_data),
    .bus_en_i   (reg_we),
    .bus_addr_i (reg_addr),
    .bus_data_i (reg_wdata),
    .rdata_1_o  (rdata_1),
    .rdata_2_o  (rdata_2),
    .rdata_3_o  (reg_rdata)
  );

endmodule

/* verification/alu_exec_tb.sv */
`timescale 1ns/10ps

module alu_exec_tb;

  localparam int CLK_HALF     = 2;
  localparam int RESET_CYCLES = 5;
  // Stimulus table entry kinds
  localparam int K_REG_WR = 0;
  localparam int K_INSTR  = 1;
  localparam int K_REG_RD = 2;
  localparam int K_ERR_WR = 3;
  localparam int K_ERR_RD = 4;

  logic                           in_clk;
  logic                           in_rst;
  logic [alu_pkg::APB_ADDR_W-1:0] paddr_i;
  logic                           psel_i;
  logic                           penable_i;
  logic                           pwrite_i;
  logic [alu_pkg::XLEN-1:0]       pwdata_i;
  logic [alu_pkg::XLEN-1:0]       prdata_o;
  logic                           pready_o;
  logic                           pslverr_o;

  int                             tbl_kind[$];
  logic [alu_pkg::APB_ADDR_W-1:0] tbl_addr[$];
  logic [alu_pkg::XLEN-1:0]       tbl_data[$];
  logic [alu_pkg::XLEN-1:0]       tbl_exp[$];
  logic [alu_pkg::XLEN-1:0]       model_regs[alu_pkg::NUM_REGS];
  logic [31:0]                    rng_state = 32'he6cf_e84d;
  int                             cycle_count = 0;
  int                             cycle_limit = 0;

  alu_exec_top uut (
    .in_clk    (in_clk),
    .in_rst    (in_rst),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o)
  );

  initial begin
    in_clk = 1'b0;
    forever #CLK_HALF in_clk = ~in_clk;
  end

  always @(posedge in_clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      report_failure();
    end
  end

  task automatic report_failure();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [alu_pkg::XLEN-1:0] got,
                            input logic [alu_pkg::XLEN-1:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
      report_failure();
    end
  endtask

  function automatic logic [31:0] xorshift();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [alu_pkg::APB_ADDR_W-1:0] reg_addr(input int idx);
    logic [alu_pkg::APB_ADDR_W-1:0] offset;
    offset = {idx[alu_pkg::APB_ADDR_W-3:0], 2'b00};
    return alu_pkg::ADDR_REG_BASE + offset;
  endfunction

  function automatic bit is_r_form(input string mn);
    return mn == "add" || mn == "sub" || mn == "sll" || mn == "slt" ||
           mn == "sltu" || mn == "xor";
  endfunction

  // Instruction word assembly through the union views
  function automatic alu_pkg::instr_u encode(input string mn, input int rd, input int rs1,
                                             input int rs2, input logic [31:0] val);
    alu_pkg::instr_u w;
    logic [2:0]      f3;
    logic [6:0]      f7;
    w  = '0;
    f3 = '0;
    f7 = alu_pkg::F7_BASE;
    case (mn)
      "add", "addi":   f3 = alu_pkg::F3_ADD_SUB;
      "sll", "slli":   f3 = alu_pkg::F3_SLL;
      "slt", "slti":   f3 = alu_pkg::F3_SLT;
      "sltu", "sltiu": f3 = alu_pkg::F3_SLTU;
      "xor", "xori":   f3 = alu_pkg::F3_XOR;
      "ori":           f3 = alu_pkg::F3_OR;
      "andi":          f3 = alu_pkg::F3_AND;
      "srli":          f3 = alu_pkg::F3_SR;
      "sub", "srai": begin
        f3 = (mn == "sub") ? alu_pkg::F3_ADD_SUB : alu_pkg::F3_SR;
        f7 = alu_pkg::F7_ALT;
      end
      default:         f3 = '0;
    endcase
    if (mn == "lui") begin
      w.u.opcode = alu_pkg::OPC_LUI;
      w.u.rd     = 5'(rd);
      w.u.imm20  = val[19:0];
    end else if (is_r_form(mn)) begin
      w.r.opcode = alu_pkg::OPC_OP;
      w.r.rd     = 5'(rd);
      w.r.funct3 = f3;
      w.r.rs1    = 5'(rs1);
      w.r.rs2    = 5'(rs2);
      w.r.funct7 = f7;
    end else begin
      w.i.opcode = alu_pkg::OPC_OP_IMM;
      w.i.rd     = 5'(rd);
      w.i.funct3 = f3;
      w.i.rs1    = 5'(rs1);
      if (mn == "slli" || mn == "srli" || mn == "srai") begin
        w.i.imm12 = {f7, val[4:0]};
      end else begin
        w.i.imm12 = val[11:0];
      end
    end
    return w;
  endfunction

  // Reference results from the RV32I definitions
  function automatic logic [alu_pkg::XLEN-1:0] ref_result(input string mn,
      input logic [alu_pkg::XLEN-1:0] a, input logic [alu_pkg::XLEN-1:0] b);
    case (mn)
      "add", "addi":   return a + b;
      "sub":           return a - b;
      "sll", "slli":   return a << b[4:0];
      "slt", "slti":   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      "sltu", "sltiu": return (a < b) ? 32'd1 : 32'd0;
      "xori":          return a ^ b;
      "ori":           return a | b;
      "andi":          return a & b;
      "srli":          return a >> b[4:0];
      "srai":          return $signed(a) >>> b[4:0];
      "lui":           return b;
      default:         return '0;
    endcase
  endfunction

  task automatic add_entry(input int kind, input logic [alu_pkg::APB_ADDR_W-1:0] addr,
                           input logic [alu_pkg::XLEN-1:0] data,
                           input logic [alu_pkg::XLEN-1:0] exp);
    tbl_kind.push_back(kind);
    tbl_addr.push_back(addr);
    tbl_data.push_back(data);
    tbl_exp.push_back(exp);
  endtask

  task automatic queue_reg_write(input int idx, input logic [alu_pkg::XLEN-1:0] val);
    add_entry(K_REG_WR, reg_addr(idx), val, '0);
    if (idx != 0) begin
      model_regs[idx] = val;
    end
  endtask

  task automatic queue_reg_read(input int idx);
    add_entry(K_REG_RD, reg_addr(idx), '0, model_regs[idx]);
  endtask

  task automatic queue_read_all();
    for (int i = 0; i < alu_pkg::NUM_REGS; i++) begin
      queue_reg_read(i);
    end
  endtask

  // Preload sources, issue, then read back rd (and sources for R-type)
  task automatic queue_alu_test(input string mn, input int rd, input int rs1, input int rs2,
                                input logic [31:0] a_val, input logic [31:0] b_val);
    logic [alu_pkg::XLEN-1:0] a;
    logic [alu_pkg::XLEN-1:0] b;
    bit                       r_form;
    r_form = is_r_form(mn);
    queue_reg_write(rs1, a_val);
    if (r_form) begin
      queue_reg_write(rs2, b_val);
    end
    a = model_regs[rs1];
    if (r_form) begin
      b = model_regs[rs2];
    end else if (mn == "lui") begin
      b = {b_val[19:0], 12'h000};
    end else begin
      b = {{20{b_val[11]}}, b_val[11:0]};
    end
    add_entry(K_INSTR, alu_pkg::ADDR_INSTR, encode(mn, rd, rs1, rs2, b_val), '0);
    if (rd != 0) begin
      model_regs[rd] = ref_result(mn, a, b);
    end
    queue_reg_read(rd);
    if (r_form) begin
      queue_reg_read(rs1);
      queue_reg_read(rs2);
    end
  endtask

  task automatic build_table();
    alu_pkg::instr_u w;
    logic [31:0]     neg;
    logic [31:0]     sh;
    for (int i = 0; i < alu_pkg::NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    // Reset state and x0
    queue_read_all();
    queue_reg_write(0, xorshift());
    queue_reg_read(0);
    for (int i = 1; i < alu_pkg::NUM_REGS; i++) begin
      queue_reg_write(i, xorshift());
    end
    queue_read_all();
    // I-type and LUI
    neg = xorshift() | 32'h8000_0000;
    sh  = xorshift() | 32'h0000_0001;
    queue_alu_test("addi", 5, 1, 0, xorshift(), xorshift());
    queue_alu_test("addi", 3, 3, 0, xorshift(), 32'h0000_0800);
    queue_alu_test("slti", 6, 2, 0, neg, 32'h0000_0005);
    queue_alu_test("sltiu", 7, 2, 0, neg, 32'h0000_0005);
    queue_alu_test("slti", 8, 4, 0, 32'h0000_0010, 32'h0000_0fff);
    queue_alu_test("sltiu", 9, 4, 0, 32'h0000_0010, 32'h0000_0fff);
    queue_alu_test("xori", 10, 11, 0, xorshift(), xorshift());
    queue_alu_test("ori", 12, 13, 0, xorshift(), xorshift());
    queue_alu_test("andi", 14, 13, 0, xorshift(), xorshift());
    queue_alu_test("slli", 15, 16, 0, xorshift(), xorshift());
    queue_alu_test("srli", 17, 16, 0, neg, sh);
    queue_alu_test("srai", 18, 16, 0, neg, sh);
    queue_alu_test("lui", 19, 0, 0, '0, xorshift());
    // R-type, sources read back afterwards
    queue_alu_test("add", 20, 21, 22, xorshift(), xorshift());
    queue_alu_test("sub", 23, 24, 25, xorshift(), xorshift());
    queue_alu_test("sll", 26, 27, 28, xorshift(), xorshift());
    queue_alu_test("slt", 29, 30, 31, xorshift(), xorshift());
    queue_alu_test("sltu", 1, 2, 4, xorshift(), xorshift());
    queue_alu_test("slt", 5, 6, 7, neg, 32'h0000_0001);
    queue_alu_test("sltu", 8, 6, 7, neg, 32'h0000_0001);
    // Illegal encodings and bad addresses
    w = encode("xor", 9, 1, 2, '0);
    add_entry(K_ERR_WR, alu_pkg::ADDR_INSTR, w, '0);
    w = encode("add", 10, 1, 2, '0);
    w.r.opcode = 7'b1100011;
    add_entry(K_ERR_WR, alu_pkg::ADDR_INSTR, w, '0);
    w = encode("srai", 11, 1, 0, 32'h0000_0003);
    w.i.imm12[11:5] = 7'b0100001;
    add_entry(K_ERR_WR, alu_pkg::ADDR_INSTR, w, '0);
    add_entry(K_ERR_RD, alu_pkg::ADDR_INSTR, '0, '0);
    add_entry(K_ERR_WR, reg_addr(alu_pkg::NUM_REGS), xorshift(), '0);
    add_entry(K_ERR_RD, reg_addr(alu_pkg::NUM_REGS), '0, '0);
    queue_read_all();
  endtask

  // One APB transfer, counting wait states
  task automatic apb_transfer(input logic write, input logic [alu_pkg::APB_ADDR_W-1:0] addr,
                              input logic [alu_pkg::XLEN-1:0] wdata,
                              output logic [alu_pkg::XLEN-1:0] rdata,
                              output logic err, output int waits);
    @(negedge in_clk);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = write;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(negedge in_clk);
    penable_i = 1'b1;
    waits     = 0;
    // Sample mid low phase, away from both edges
    #1;
    while (!pready_o) begin
      waits++;
      @(negedge in_clk);
      #1;
    end
    rdata = prdata_o;
    err   = pslverr_o;
    @(negedge in_clk);
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  initial begin
    int                       waits;
    logic [alu_pkg::XLEN-1:0] rdata;
    logic                     err;
    logic                     is_write;
    logic                     exp_err;
    in_rst    = 1'b0;
    paddr_i   = '0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    pwdata_i  = '0;
    build_table();
    cycle_limit = tbl_kind.size() * 6 + RESET_CYCLES + 20;
    repeat (RESET_CYCLES) @(posedge in_clk);
    @(negedge in_clk);
    in_rst = 1'b1;
    foreach (tbl_kind[n]) begin
      is_write = tbl_kind[n] == K_REG_WR || tbl_kind[n] == K_INSTR || tbl_kind[n] == K_ERR_WR;
      exp_err  = tbl_kind[n] == K_ERR_WR || tbl_kind[n] == K_ERR_RD;
      apb_transfer(is_write, tbl_addr[n], tbl_data[n], rdata, err, waits);
      check_err($sformatf("pslverr_o @0x%h", tbl_addr[n]), err, exp_err);
      check_word($sformatf("pready_o wait states @0x%h", tbl_addr[n]), waits,
                 (tbl_kind[n] == K_INSTR) ? 2 : 0);
      if (tbl_kind[n] == K_REG_RD) begin
        check_word($sformatf("prdata_o @0x%h", tbl_addr[n]), rdata, tbl_exp[n]);
      end
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule

/* compile.f */
hdl/alu_pkg.sv
hdl/alu_regfile.sv
hdl/alu_decoder.sv
hdl/alu_execute.sv
hdl/alu_apb_slave.sv
hdl/alu_exec_top.sv
verification/alu_exec_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f compile.f --top-module alu_exec_tb \
  -Mdir obj_dir -o alu_exec_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/alu_exec_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
  exit 0
fi
echo "Simulation did not report a pass"
exit 1
